/* beat_fifo.sv */
`timescale 1ns/1ps

module beat_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     aclk,
    input  logic     reset_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    output logic     full_o,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     empty_o
);

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int FILL_W = $clog2(DEPTH + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [FILL_W-1:0] fill;

    // wrap at DEPTH so non power of two depths work too
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o     = (fill == FILL_W'(DEPTH));
    assign empty_o    = (fill == '0);
    // head of the queue is visible without a read cycle
    assign pop_data_o = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_i) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_i, pop_i})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // the owner must gate push and pop with the flags
    a_no_push_full: assert property (@(posedge aclk) disable iff (reset_i)
        push_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge aclk) disable iff (reset_i)
        pop_i |-> !empty_o);

endmodule

/* evb_cfg_pkg.sv */
package evb_cfg_pkg;

    // number of incoming link streams
    localparam int NUM_LINKS = 4;

    // width of one link word
    localparam int LINK_DATA_W = 32;

    // width of header beats and of the output event stream
    localparam int EV_DATA_W = 64;

    // run configuration, held stable while no event is in flight
    typedef struct packed {
        // one bit per link, set means the link takes part in events
        logic [NUM_LINKS-1:0] link_mask;
    } evb_cfg_t;

endpackage

/* evb_stream_pkg.sv */
package evb_stream_pkg;

    // one word from a link, last marks the end of a fragment
    typedef struct packed {
        logic                                last;
        logic [evb_cfg_pkg::LINK_DATA_W-1:0] data;
    } link_beat_t;

    // one header or output beat, last marks the end of a header or event
    typedef struct packed {
        logic                              last;
        logic [evb_cfg_pkg::EV_DATA_W-1:0] data;
    } ev_beat_t;

    // all link beats side by side, link 0 in the lowest slot
    typedef link_beat_t [evb_cfg_pkg::NUM_LINKS-1:0] link_beat_vec_t;

endpackage

/* event_builder_top.sv */
`timescale 1ns/1ps

module event_builder_top #(
    parameter int LINK_FIFO_DEPTH = 16,
    parameter int HDR_FIFO_DEPTH  = 8,
    parameter int CNT_W           = 4
) (
    input  logic                              aclk,
    input  logic                              reset_i,
    input  logic                              event_open_i,
    input  evb_cfg_pkg::evb_cfg_t             cfg_i,
    input  logic [evb_cfg_pkg::NUM_LINKS-1:0] s_link_tvalid_i,
    input  evb_stream_pkg::link_beat_vec_t    s_link_beat_i,
    output logic [evb_cfg_pkg::NUM_LINKS-1:0] s_link_tready_o,
    input  logic                              s_hdr_tvalid_i,
    input  evb_stream_pkg::ev_beat_t          s_hdr_beat_i,
    output logic                              s_hdr_tready_o,
    output logic                              m_ev_tvalid_o,
    output evb_stream_pkg::ev_beat_t          m_ev_beat_o,
    input  logic                              m_ev_tready_i,
    output logic                              evin_complete_o
);

    import evb_cfg_pkg::*;
    import evb_stream_pkg::*;

    // link read port between intake and merger
    logic [NUM_LINKS-1:0] link_valid;
    link_beat_vec_t       link_beat;
    logic [NUM_LINKS-1:0] link_pop;
    logic [NUM_LINKS-1:0] frag_avail;

    // header read port
    logic                 hdr_valid;
    ev_beat_t             hdr_beat;
    logic                 hdr_pop;
    logic                 hdr_avail;

    link_intake #(
        .LINK_FIFO_DEPTH (LINK_FIFO_DEPTH),
        .CNT_W           (CNT_W)
    ) u_link_intake (
        .aclk            (aclk),
        .reset_i         (reset_i),
        .event_open_i    (event_open_i),
        .cfg_i           (cfg_i),
        .s_link_tvalid_i (s_link_tvalid_i),
        .s_link_beat_i   (s_link_beat_i),
        .s_link_tready_o (s_link_tready_o),
        .link_valid_o    (link_valid),
        .link_beat_o     (link_beat),
        .link_pop_i      (link_pop),
        .frag_avail_o    (frag_avail)
    );

    header_intake #(
        .HDR_FIFO_DEPTH (HDR_FIFO_DEPTH),
        .CNT_W          (CNT_W)
    ) u_header_intake (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .s_hdr_tvalid_i (s_hdr_tvalid_i),
        .s_hdr_beat_i   (s_hdr_beat_i),
        .s_hdr_tready_o (s_hdr_tready_o),
        .hdr_valid_o    (hdr_valid),
        .hdr_beat_o     (hdr_beat),
        .hdr_pop_i      (hdr_pop),
        .hdr_avail_o    (hdr_avail)
    );

    event_merger u_merger (
        .aclk            (aclk),
        .reset_i         (reset_i),
        .cfg_i           (cfg_i),
        .link_valid_i    (link_valid),
        .link_beat_i     (link_beat),
        .link_pop_o      (link_pop),
        .frag_avail_i    (frag_avail),
        .hdr_valid_i     (hdr_valid),
        .hdr_beat_i      (hdr_beat),
        .hdr_pop_o       (hdr_pop),
        .hdr_avail_i     (hdr_avail),
        .m_ev_tvalid_o   (m_ev_tvalid_o),
        .m_ev_beat_o     (m_ev_beat_o),
        .m_ev_tready_i   (m_ev_tready_i),
        .evin_complete_o (evin_complete_o)
    );

endmodule

/* event_merger.sv */
`timescale 1ns/1ps

module event_merger (
    input  logic                              aclk,
    input  logic                              reset_i,
    input  evb_cfg_pkg::evb_cfg_t             cfg_i,
    input  logic [evb_cfg_pkg::NUM_LINKS-1:0] link_valid_i,
    input  evb_stream_pkg::link_beat_vec_t    link_beat_i,
    output logic [evb_cfg_pkg::NUM_LINKS-1:0] link_pop_o,
    input  logic [evb_cfg_pkg::NUM_LINKS-1:0] frag_avail_i,
    input  logic                              hdr_valid_i,
    input  evb_stream_pkg::ev_beat_t          hdr_beat_i,
    output logic                              hdr_pop_o,
    input  logic                              hdr_avail_i,
    output logic                              m_ev_tvalid_o,
    output evb_stream_pkg::ev_beat_t          m_ev_beat_o,
    input  logic                              m_ev_tready_i,
    output logic                              evin_complete_o
);

    import evb_cfg_pkg::*;
    import evb_stream_pkg::*;

    localparam int IDX_W = (NUM_LINKS > 1) ? $clog2(NUM_LINKS) : 1;
    localparam int TAG_W = EV_DATA_W - LINK_DATA_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_LINK
    } state_t;

    state_t                state_q;
    logic [NUM_LINKS-1:0]  mask_q;
    logic [IDX_W-1:0]      link_idx;
    logic                  first_q;
    logic                  start;
    logic [IDX_W:0]        first_sel;
    logic [IDX_W:0]        next_sel;
    link_beat_t            cur;

    // lowest enabled link above index after, msb flags a hit
    function automatic logic [IDX_W:0] find_link(input logic [NUM_LINKS-1:0] mask,
                                                  input int after);
        logic [IDX_W:0] res;
        res = '0;
        for (int l = NUM_LINKS - 1; l >= 0; l--) begin
            if (l > after && mask[l]) begin
                res = {1'b1, IDX_W'(l)};
            end
        end
        return res;
    endfunction

    // a header and one fragment on every enabled link
    assign start     = hdr_avail_i && ((frag_avail_i | ~cfg_i.link_mask) == '1);
    assign first_sel = find_link(mask_q, -1);
    assign next_sel  = find_link(mask_q, int'(link_idx));
    assign cur       = link_beat_i[link_idx];

    always_comb begin
        m_ev_tvalid_o = 1'b0;
        m_ev_beat_o   = '0;
        hdr_pop_o     = 1'b0;
        link_pop_o    = '0;
        case (state_q)
            ST_HEADER: begin
                m_ev_tvalid_o    = hdr_valid_i;
                m_ev_beat_o      = hdr_beat_i;
                // header closes the event only when no link is enabled
                m_ev_beat_o.last = hdr_beat_i.last && (mask_q == '0);
                hdr_pop_o        = hdr_valid_i && m_ev_tready_i;
            end
            ST_LINK: begin
                m_ev_tvalid_o        = link_valid_i[link_idx];
                m_ev_beat_o.data     = {TAG_W'(link_idx), cur.data};
                m_ev_beat_o.last     = cur.last && !next_sel[IDX_W];
                link_pop_o[link_idx] = link_valid_i[link_idx] && m_ev_tready_i;
            end
            default: begin
                m_ev_tvalid_o = 1'b0;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q  <= ST_IDLE;
            mask_q   <= '0;
            link_idx <= '0;
            first_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        mask_q  <= cfg_i.link_mask;
                        first_q <= 1'b1;
                        state_q <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    first_q <= 1'b0;
                    if (hdr_pop_o && hdr_beat_i.last) begin
                        if (first_sel[IDX_W]) begin
                            link_idx <= first_sel[IDX_W-1:0];
                            state_q  <= ST_LINK;
                        end else begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                ST_LINK: begin
                    if (link_pop_o[link_idx] && cur.last) begin
                        if (next_sel[IDX_W]) begin
                            link_idx <= next_sel[IDX_W-1:0];
                        end else begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // first header beat is on the bus in the first header cycle
    assign evin_complete_o = (state_q == ST_HEADER) && first_q;

    a_hold_under_stall: assert property (@(posedge aclk) disable iff (reset_i)
        (m_ev_tvalid_o && !m_ev_tready_i) |=> (m_ev_tvalid_o && $stable(m_ev_beat_o)));

endmodule

/* header_intake.sv */
`timescale 1ns/1ps

module header_intake #(
    parameter int HDR_FIFO_DEPTH = 8,
    parameter int CNT_W          = 4
) (
    input  logic                     aclk,
    input  logic                     reset_i,
    input  logic                     s_hdr_tvalid_i,
    input  evb_stream_pkg::ev_beat_t s_hdr_beat_i,
    output logic                     s_hdr_tready_o,
    output logic                     hdr_valid_o,
    output evb_stream_pkg::ev_beat_t hdr_beat_o,
    input  logic                     hdr_pop_i,
    output logic                     hdr_avail_o
);

    import evb_stream_pkg::*;

    logic             fifo_full;
    logic             fifo_empty;
    logic             push;
    logic             hdr_full;
    logic             stored_last;
    logic             popped_last;
    logic [CNT_W-1:0] hdr_cnt;

    // headers are taken whenever there is room, event open or not
    assign hdr_full       = &hdr_cnt;
    assign s_hdr_tready_o = !fifo_full && !hdr_full;
    assign push           = s_hdr_tvalid_i && s_hdr_tready_o;

    beat_fifo #(
        .payload_t (ev_beat_t),
        .DEPTH     (HDR_FIFO_DEPTH)
    ) u_fifo (
        .aclk        (aclk),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (s_hdr_beat_i),
        .full_o      (fifo_full),
        .pop_i       (hdr_pop_i),
        .pop_data_o  (hdr_beat_o),
        .empty_o     (fifo_empty)
    );

    assign hdr_valid_o = !fifo_empty;

    // complete headers waiting in the fifo
    assign stored_last = push && s_hdr_beat_i.last;
    assign popped_last = hdr_pop_i && hdr_beat_o.last;

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            hdr_cnt <= '0;
        end else if (stored_last && !popped_last) begin
            hdr_cnt <= hdr_cnt + 1'b1;
        end else if (popped_last && !stored_last) begin
            hdr_cnt <= hdr_cnt - 1'b1;
        end
    end

    assign hdr_avail_o = (hdr_cnt != '0);

endmodule

/* link_intake.sv */
`timescale 1ns/1ps

module link_intake #(
    parameter int LINK_FIFO_DEPTH = 16,
    parameter int CNT_W           = 4
) (
    input  logic                                  aclk,
    input  logic                                  reset_i,
    input  logic                                  event_open_i,
    input  evb_cfg_pkg::evb_cfg_t                 cfg_i,
    input  logic [evb_cfg_pkg::NUM_LINKS-1:0]     s_link_tvalid_i,
    input  evb_stream_pkg::link_beat_vec_t        s_link_beat_i,
    output logic [evb_cfg_pkg::NUM_LINKS-1:0]     s_link_tready_o,
    output logic [evb_cfg_pkg::NUM_LINKS-1:0]     link_valid_o,
    output evb_stream_pkg::link_beat_vec_t        link_beat_o,
    input  logic [evb_cfg_pkg::NUM_LINKS-1:0]     link_pop_i,
    output logic [evb_cfg_pkg::NUM_LINKS-1:0]     frag_avail_o
);

    import evb_cfg_pkg::*;
    import evb_stream_pkg::*;

    // fifo heads, packed into the read port below
    link_beat_t head [NUM_LINKS];

    always_comb begin
        for (int l = 0; l < NUM_LINKS; l++) begin
            link_beat_o[l] = head[l];
        end
    end

    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
        logic             accept;
        logic             fifo_full;
        logic             fifo_empty;
        logic             push;
        logic             stored_last;
        logic             popped_last;
        logic             frag_full;
        logic [CNT_W-1:0] frag_cnt;

        // closed interface or masked link: swallow everything
        assign accept = event_open_i && cfg_i.link_mask[i];

        // stall when the fragment counter could not take another fragment
        assign frag_full          = &frag_cnt;
        assign push               = accept && s_link_tvalid_i[i] && !fifo_full && !frag_full;
        assign s_link_tready_o[i] = !accept || (!fifo_full && !frag_full);

        beat_fifo #(
            .payload_t (link_beat_t),
            .DEPTH     (LINK_FIFO_DEPTH)
        ) u_fifo (
            .aclk        (aclk),
            .reset_i     (reset_i),
            .push_i      (push),
            .push_data_i (s_link_beat_i[i]),
            .full_o      (fifo_full),
            .pop_i       (link_pop_i[i]),
            .pop_data_o  (head[i]),
            .empty_o     (fifo_empty)
        );

        assign link_valid_o[i] = !fifo_empty;

        // count complete fragments held in the fifo
        assign stored_last = push && s_link_beat_i[i].last;
        assign popped_last = link_pop_i[i] && head[i].last;

        always_ff @(posedge aclk) begin
            if (reset_i) begin
                frag_cnt <= '0;
            end else if (stored_last && !popped_last) begin
                frag_cnt <= frag_cnt + 1'b1;
            end else if (popped_last && !stored_last) begin
                frag_cnt <= frag_cnt - 1'b1;
            end
        end

        assign frag_avail_o[i] = (frag_cnt != '0);

        // the merger only drains a fragment it was told is complete
        a_frag_no_underflow: assert property (@(posedge aclk) disable iff (reset_i)
            (popped_last && !stored_last) |-> (frag_cnt != '0));
    end

endmodule

/* list.f */
+incdir+.
evb_cfg_pkg.sv
evb_stream_pkg.sv
beat_fifo.sv
link_intake.sv
header_intake.sv
event_merger.sv
event_builder_top.sv
tb_event_builder.sv

/* tb_event_ref.svh */
`ifndef TB_EVENT_REF_SVH
`define TB_EVENT_REF_SVH

localparam int TAG_W    = EV_DATA_W - LINK_DATA_W;
localparam int MAX_HDR  = 3;
localparam int MAX_FRAG = 6;

logic [31:0]            stim_lfsr = 32'h422b_ea8e;
logic [EV_DATA_W-1:0]   hdr_word [MAX_HDR];
int                     hdr_len;
logic [LINK_DATA_W-1:0] frag_word [NUM_LINKS][MAX_FRAG];
int                     frag_len [NUM_LINKS];
ev_beat_t               exp_q [$];

// right shifting galois lfsr, one step per bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        stim_lfsr = lfsr_next(stim_lfsr);
        v         = {v[30:0], stim_lfsr[0]};
    end
    return v;
endfunction

function automatic void gen_header();
    hdr_len = 1 + int'(take_bits(2) % 3);
    for (int h = 0; h < hdr_len; h++) begin
        hdr_word[h][63:32] = take_bits(32);
        hdr_word[h][31:0]  = take_bits(32);
    end
endfunction

// one fragment per link, masked links get one too
function automatic void gen_frags();
    for (int l = 0; l < NUM_LINKS; l++) begin
        frag_len[l] = 1 + int'(take_bits(3) % 6);
        for (int w = 0; w < frag_len[l]; w++) begin
            frag_word[l][w] = take_bits(32);
        end
    end
endfunction

// header first, then enabled links in order with the link number on top
function automatic void expected_event(input logic [NUM_LINKS-1:0] mask);
    ev_beat_t b;
    int       last_link;
    last_link = -1;
    for (int l = 0; l < NUM_LINKS; l++) begin
        if (mask[l]) begin
            last_link = l;
        end
    end
    for (int h = 0; h < hdr_len; h++) begin
        b.data = hdr_word[h];
        b.last = (h == hdr_len - 1) && (last_link < 0);
        exp_q.push_back(b);
    end
    for (int l = 0; l < NUM_LINKS; l++) begin
        for (int w = 0; w < frag_len[l] && mask[l]; w++) begin
            b.data = {TAG_W'(l), frag_word[l][w]};
            b.last = (l == last_link) && (w == frag_len[l] - 1);
            exp_q.push_back(b);
        end
    end
endfunction

`endif

/* tb_event_builder.sv */
`timescale 1ns/1ps

module tb_event_builder;

    import evb_cfg_pkg::*;
    import evb_stream_pkg::*;

    `include "tb_event_ref.svh"

    localparam int CLK_PERIOD      = 20;
    // eight events plus one dropped set of fragments at worst case length
    localparam int MAX_STIM_BEATS  = 9 * (MAX_HDR + NUM_LINKS * MAX_FRAG);
    localparam int WATCHDOG_CYCLES = MAX_STIM_BEATS * 20 + 1000;

    logic                 aclk;
    logic                 reset_i;
    logic                 event_open_i;
    evb_cfg_t             cfg_i;
    logic [NUM_LINKS-1:0] s_link_tvalid_i;
    link_beat_vec_t       s_link_beat_i;
    logic [NUM_LINKS-1:0] s_link_tready_o;
    logic                 s_hdr_tvalid_i;
    ev_beat_t             s_hdr_beat_i;
    logic                 s_hdr_tready_o;
    logic                 m_ev_tvalid_o;
    ev_beat_t             m_ev_beat_o;
    logic                 m_ev_tready_i;
    logic                 evin_complete_o;

    // output ready mode where 0 is always high, 1 random and 2 held low
    int          out_mode = 0;
    logic [31:0] ready_lfsr = 32'h422b_ea8e;
    logic        next_is_first = 1'b1;
    int          err_cnt = 0;
    int          complete_cnt = 0;
    int          ev_out_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    event_builder_top #(
        .LINK_FIFO_DEPTH (16),
        .HDR_FIFO_DEPTH  (8),
        .CNT_W           (4)
    ) u_dut (.*);

    initial aclk = 1'b0;
    always #(CLK_PERIOD / 2) aclk = ~aclk;

    // hold the beat until ready is seen high in the low phase
    task automatic put_hdr_beat(input ev_beat_t b);
        logic rdy;
        s_hdr_tvalid_i = 1'b1;
        s_hdr_beat_i   = b;
        do begin
            #(CLK_PERIOD / 4);
            rdy = s_hdr_tready_o;
            @(negedge aclk);
        end while (!rdy);
        s_hdr_tvalid_i = 1'b0;
    endtask

    task automatic put_link_beat(input int l, input link_beat_t b);
        logic rdy;
        logic drop;
        drop               = !event_open_i || !cfg_i.link_mask[l];
        s_link_tvalid_i[l] = 1'b1;
        s_link_beat_i[l]   = b;
        do begin
            #(CLK_PERIOD / 4);
            rdy = s_link_tready_o[l];
            if (drop && !rdy) begin
                $display("Error at %0t: link %0d not ready although its beats are dropped",
                         $time, l);
                err_cnt++;
                rdy = 1'b1;
            end
            @(negedge aclk);
        end while (!rdy);
        s_link_tvalid_i[l] = 1'b0;
    endtask

    task automatic send_header();
        ev_beat_t b;
        for (int h = 0; h < hdr_len; h++) begin
            b.data = hdr_word[h];
            b.last = (h == hdr_len - 1);
            put_hdr_beat(b);
        end
    endtask

    task automatic send_links();
        link_beat_t b;
        for (int l = 0; l < NUM_LINKS; l++) begin
            for (int w = 0; w < frag_len[l]; w++) begin
                b.data = frag_word[l][w];
                b.last = (w == frag_len[l] - 1);
                put_link_beat(l, b);
            end
        end
    endtask

    task automatic send_event();
        gen_header();
        gen_frags();
        expected_event(cfg_i.link_mask);
        send_header();
        send_links();
    endtask

    task automatic finish_test(input int num, input string name, input int err_before);
        while (exp_q.size() != 0) begin
            @(negedge aclk);
        end
        repeat (4) @(negedge aclk);
        if (complete_cnt != ev_out_cnt) begin
            $display("Mismatch at %0t: %0d completion pulses for %0d events",
                     $time, complete_cnt, ev_out_cnt);
            err_cnt++;
        end
        if (err_cnt == err_before) begin
            pass_cnt++;
            $display("test %0d %s: pass", num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: fail, %0d errors", num, name, err_cnt - err_before);
        end
    endtask

    // drives output ready and checks every transferred beat
    always @(negedge aclk) begin : compare_proc
        ev_beat_t exp_b;
        logic     rdy;
        rdy = (out_mode == 0);
        if (out_mode == 1) begin
            ready_lfsr = lfsr_next(ready_lfsr);
            rdy        = ready_lfsr[0];
        end
        m_ev_tready_i = rdy;
        if (evin_complete_o) begin
            complete_cnt++;
            if (!m_ev_tvalid_o || !next_is_first) begin
                $display("Error at %0t: completion pulse away from an event start", $time);
                err_cnt++;
            end
        end
        if (m_ev_tvalid_o && rdy) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: output beat %h with no event expected",
                         $time, m_ev_beat_o.data);
                err_cnt++;
            end else begin
                exp_b = exp_q.pop_front();
                if (m_ev_beat_o.data !== exp_b.data || m_ev_beat_o.last !== exp_b.last) begin
                    $display("Mismatch at %0t: got %h last %b, expected %h last %b", $time,
                             m_ev_beat_o.data, m_ev_beat_o.last, exp_b.data, exp_b.last);
                    err_cnt++;
                end
                next_is_first = exp_b.last;
                if (exp_b.last) begin
                    ev_out_cnt++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Error: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int          err_before;
        logic [31:0] first_seed;
        reset_i         = 1'b1;
        event_open_i    = 1'b0;
        cfg_i           = '0;
        s_link_tvalid_i = '0;
        s_link_beat_i   = '0;
        s_hdr_tvalid_i  = 1'b0;
        s_hdr_beat_i    = '0;
        m_ev_tready_i   = 1'b0;
        repeat (5) @(negedge aclk);
        reset_i = 1'b0;

        err_before = err_cnt;
        repeat (10) begin
            @(negedge aclk);
            if (m_ev_tvalid_o || evin_complete_o) begin
                $display("Error at %0t: output active after reset with no input", $time);
                err_cnt++;
            end
        end
        event_open_i    = 1'b1;
        cfg_i.link_mask = 4'b1111;
        first_seed      = stim_lfsr;
        send_event();
        finish_test(1, "all links", err_before);

        err_before      = err_cnt;
        cfg_i.link_mask = 4'b0101;
        send_event();
        finish_test(2, "masked links", err_before);
        err_before      = err_cnt;
        cfg_i.link_mask = 4'b0000;
        send_event();
        finish_test(3, "header only", err_before);

        // header arrives while closed and the fragments sent then are lost
        err_before      = err_cnt;
        cfg_i.link_mask = 4'b1111;
        event_open_i    = 1'b0;
        gen_header();
        send_header();
        gen_frags();
        send_links();
        repeat (20) begin
            @(negedge aclk);
            if (m_ev_tvalid_o) begin
                $display("Error at %0t: output started while the interface was closed", $time);
                err_cnt++;
            end
        end
        event_open_i = 1'b1;
        gen_frags();
        expected_event(cfg_i.link_mask);
        send_links();
        finish_test(4, "closed interface", err_before);

        // replay the first event under random back-pressure
        err_before = err_cnt;
        out_mode   = 1;
        stim_lfsr  = first_seed;
        send_event();
        finish_test(5, "back-pressure", err_before);

        err_before = err_cnt;
        out_mode   = 2;
        send_event();
        send_event();
        out_mode = 1;
        send_event();
        finish_test(6, "queued events", err_before);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
